// ==== logic/console_pkg.sv ====
package console_pkg;

	// ####################################################################
	// widths

	localparam int W_SRAM_ADDR = 18;
	localparam int W_SRAM_DATA = 16;
	localparam int W_BUS = 32;
	localparam int W_STRB = W_BUS / 8;
	localparam int W_RESP = 2;
	localparam int N_BTN = 5;
	localparam int N_LED = 8;

	typedef logic [W_SRAM_ADDR-1:0] sram_addr_t; // halfword address
	typedef logic [W_SRAM_DATA-1:0] sram_data_t;
	typedef logic [W_BUS-1:0] bus_addr_t;
	typedef logic [W_BUS-1:0] bus_data_t;
	typedef logic [W_STRB-1:0] bus_strb_t;
	typedef logic [W_RESP-1:0] bus_resp_t;
	typedef logic [N_BTN-1:0] btn_t; // up, down, left, right, a
	typedef logic [N_LED-1:0] led_t;

	// ####################################################################
	// address map and responses

	localparam bus_addr_t SRAM_BASE = 32'h0000_0000;
	localparam bus_addr_t GPIO_BASE = 32'h8000_0000;
	localparam bus_addr_t GPIO_OUT_OFS = 32'h0; // bit 0 user led
	localparam bus_addr_t GPIO_IN_OFS = 32'h4; // buttons, read only

	localparam bus_resp_t RESP_OKAY = 2'b00;
	localparam bus_resp_t RESP_DECERR = 2'b11;

	// timing
	localparam int RESET_STRETCH = 16;
	localparam int SRAM_WAIT = 2; // strobe cycles per halfword
	localparam int SRAM_RD_WAIT = SRAM_WAIT + 2; // plus phy return delay

	typedef logic [$clog2(RESET_STRETCH+1)-1:0] rst_cnt_t;
	typedef logic [$clog2(SRAM_RD_WAIT+1)-1:0] wait_cnt_t;

	typedef struct packed {
		sram_addr_t addr;
		sram_data_t dq_out;
		logic dq_oe;
		logic we_n;
		logic oe_n;
		logic [1:0] byte_n; // [0] low byte
	} sram_ctrl_s;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic a;
	} pad_in_s;

	typedef enum logic [1:0] {IDLE, SRAM_LO, SRAM_HI, RESP} ctrl_state_e;

endpackage

// ==== logic/reset_gen.sv ====
module reset_gen (
	input  logic clk_sys,
	input  logic rst_n,
	output logic rst_sys_n
);

	logic [1:0] rst_sync;
	console_pkg::rst_cnt_t cnt;

	always_ff @(posedge clk_sys) begin
		rst_sync <= {rst_sync[0], rst_n};
	end

	// stretch gives the block rams time to come up after configuration
	always_ff @(posedge clk_sys) begin
		if (!rst_sync[1]) begin
			cnt <= '0;
			rst_sys_n <= 1'b0;
		end else if (cnt != console_pkg::rst_cnt_t'(console_pkg::RESET_STRETCH)) begin
			cnt <= cnt + 1'b1;
			rst_sys_n <= 1'b0;
		end else begin
			rst_sys_n <= 1'b1; // count reached, release
		end
	end

endmodule

// ==== logic/bus_ctrl.sv ====
module bus_ctrl (
	input  logic                    clk_sys,
	input  logic                    rst_sys_n,

	input  console_pkg::bus_addr_t  awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  console_pkg::bus_data_t  wdata,
	input  console_pkg::bus_strb_t  wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output console_pkg::bus_resp_t  bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  console_pkg::bus_addr_t  araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output console_pkg::bus_data_t  rdata,
	output console_pkg::bus_resp_t  rresp,
	output logic                    rvalid,
	input  logic                    rready,

	output console_pkg::sram_ctrl_s sram_cmd,
	input  console_pkg::sram_data_t sram_rd,
	input  console_pkg::btn_t       btn,
	output logic                    led_load,
	output logic                    led_value,
	input  logic                    led_state
);

	console_pkg::ctrl_state_e state;
	console_pkg::wait_cnt_t cnt;
	console_pkg::wait_cnt_t phase_last;
	logic is_write;
	console_pkg::bus_resp_t resp_q;

	logic [console_pkg::W_SRAM_ADDR-2:0] word_q; // word index
	console_pkg::bus_data_t wdata_q;
	console_pkg::bus_strb_t wstrb_q;
	console_pkg::bus_data_t rdata_q;

	logic idle, wr_hs, rd_hs, phase_end;
	console_pkg::bus_addr_t dec_addr;
	logic hit_sram, hit_out, hit_in;
	logic [1:0] strb_pair;

	// ####################################################################
	// handshake and decode

	assign idle = state == console_pkg::IDLE;
	assign wr_hs = idle && awvalid && wvalid; // writes win
	assign rd_hs = idle && arvalid && !(awvalid || wvalid);

	assign awready = wr_hs;
	assign wready = wr_hs;
	assign arready = rd_hs;

	assign dec_addr = wr_hs ? awaddr : araddr;
	assign hit_sram = dec_addr[31:20] == console_pkg::SRAM_BASE[31:20];
	assign hit_out = {dec_addr[31:2], 2'b00} == console_pkg::GPIO_BASE + console_pkg::GPIO_OUT_OFS;
	assign hit_in = {dec_addr[31:2], 2'b00} == console_pkg::GPIO_BASE + console_pkg::GPIO_IN_OFS;

	assign led_load = wr_hs && hit_out && wstrb[0];
	assign led_value = wdata[0];

	assign phase_last = is_write ? console_pkg::wait_cnt_t'(console_pkg::SRAM_WAIT) :
		console_pkg::wait_cnt_t'(console_pkg::SRAM_RD_WAIT);
	assign phase_end = cnt == phase_last;

	// ####################################################################
	// state machine

	always_ff @(posedge clk_sys) begin
		if (!rst_sys_n) begin
			state <= console_pkg::IDLE;
			cnt <= '0;
			is_write <= 1'b0;
			resp_q <= console_pkg::RESP_OKAY;
		end else begin
			case (state)
				console_pkg::IDLE: begin
					cnt <= '0;
					if (wr_hs || rd_hs) begin
						is_write <= wr_hs;
						// input register writes are dropped but answer okay
						resp_q <= (hit_sram || hit_out || hit_in) ?
							console_pkg::RESP_OKAY : console_pkg::RESP_DECERR;
						state <= hit_sram ? console_pkg::SRAM_LO : console_pkg::RESP;
					end
				end
				console_pkg::SRAM_LO, console_pkg::SRAM_HI: begin
					if (phase_end) begin
						cnt <= '0;
						state <= (state == console_pkg::SRAM_LO) ?
							console_pkg::SRAM_HI : console_pkg::RESP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					if (is_write ? bready : rready)
						state <= console_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_hs || rd_hs) begin
			word_q <= dec_addr[18:2]; // bit 19 aliases
			wdata_q <= wdata;
			wstrb_q <= wstrb;
			if (hit_in)
				rdata_q <= console_pkg::bus_data_t'(btn);
			else if (hit_out)
				rdata_q <= console_pkg::bus_data_t'(led_state);
			else
				rdata_q <= '0;
		end else if (!is_write && phase_end) begin
			if (state == console_pkg::SRAM_LO)
				rdata_q[15:0] <= sram_rd;
			else if (state == console_pkg::SRAM_HI)
				rdata_q[31:16] <= sram_rd;
		end
	end

	assign bvalid = state == console_pkg::RESP && is_write;
	assign rvalid = state == console_pkg::RESP && !is_write;
	assign bresp = resp_q;
	assign rresp = resp_q;
	assign rdata = rdata_q;

	// ####################################################################
	// sram command that the phy registers again

	assign strb_pair = (state == console_pkg::SRAM_HI) ? wstrb_q[3:2] : wstrb_q[1:0];

	always_comb begin
		sram_cmd.addr = {word_q, state == console_pkg::SRAM_HI};
		sram_cmd.dq_out = (state == console_pkg::SRAM_HI) ? wdata_q[31:16] : wdata_q[15:0];
		sram_cmd.dq_oe = 1'b0;
		sram_cmd.we_n = 1'b1;
		sram_cmd.oe_n = 1'b1;
		sram_cmd.byte_n = 2'b11;
		if (state == console_pkg::SRAM_LO || state == console_pkg::SRAM_HI) begin
			if (is_write) begin
				sram_cmd.dq_oe = 1'b1;
				sram_cmd.we_n = !(cnt < console_pkg::SRAM_WAIT); // last cycle is hold
				sram_cmd.byte_n = ~strb_pair;
			end else begin
				sram_cmd.oe_n = 1'b0;
				sram_cmd.byte_n = 2'b00;
			end
		end
	end

endmodule

// ==== logic/sram_phy.sv ====
module sram_phy (
	input  logic                          clk_sys,
	input  logic                          rst_sys_n,
	input  console_pkg::sram_ctrl_s       ctrl,
	output console_pkg::sram_data_t       rd_data,

	output console_pkg::sram_addr_t       sram_addr,
	inout  wire console_pkg::sram_data_t  sram_dq,
	output logic                          sram_we_n,
	output logic                          sram_oe_n,
	output logic [1:0]                    sram_byte_n
);

	logic dq_oe_q;
	console_pkg::sram_data_t dq_out_q;
	console_pkg::sram_data_t dq_sync;

	// ####################################################################
	// outbound pins, all from flops

	always_ff @(posedge clk_sys) begin
		if (!rst_sys_n) begin
			dq_oe_q <= 1'b0;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b1;
			sram_byte_n <= 2'b11;
		end else begin
			dq_oe_q <= ctrl.dq_oe;
			sram_we_n <= ctrl.we_n;
			sram_oe_n <= ctrl.oe_n;
			sram_byte_n <= ctrl.byte_n;
		end
	end

	always_ff @(posedge clk_sys) begin
		sram_addr <= ctrl.addr;
		dq_out_q <= ctrl.dq_out;
	end

	assign sram_dq = dq_oe_q ? dq_out_q : 'z;

	// return path, two stages
	always_ff @(posedge clk_sys) begin
		dq_sync <= sram_dq;
		rd_data <= dq_sync;
	end

endmodule

// ==== logic/gpio_pads.sv ====
module gpio_pads (
	input  logic                 clk_sys,
	input  logic                 rst_sys_n,
	input  console_pkg::pad_in_s pads,
	input  logic                 led_load,
	input  logic                 led_value,
	input  logic                 uart_idle,
	output console_pkg::btn_t    btn,
	output logic                 led_state,
	output console_pkg::led_t    led
);

	console_pkg::btn_t pad_meta;
	console_pkg::btn_t pad_sync;
	logic led_user;

	// ####################################################################
	// buttons

	// pads idle high, reset to released
	always_ff @(posedge clk_sys) begin
		if (!rst_sys_n) begin
			pad_meta <= '1;
			pad_sync <= '1;
		end else begin
			pad_meta <= console_pkg::btn_t'(pads);
			pad_sync <= pad_meta;
		end
	end

	assign btn = ~pad_sync; // pressed reads 1

	// ####################################################################
	// leds

	always_ff @(posedge clk_sys) begin
		if (!rst_sys_n)
			led_user <= 1'b0;
		else if (led_load)
			led_user <= led_value;
	end

	assign led_state = led_user;

	assign led = {
		!uart_idle,
		1'b0,       // spare slot
		btn,
		led_user
	};

endmodule

// ==== logic/console_top.sv ====
module console_top (
	input  logic                         clk_sys,
	input  logic                         rst_n,

	input  console_pkg::bus_addr_t       awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  console_pkg::bus_data_t       wdata,
	input  console_pkg::bus_strb_t       wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	output console_pkg::bus_resp_t       bresp,
	output logic                         bvalid,
	input  logic                         bready,
	input  console_pkg::bus_addr_t       araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output console_pkg::bus_data_t       rdata,
	output console_pkg::bus_resp_t       rresp,
	output logic                         rvalid,
	input  logic                         rready,

	input  console_pkg::pad_in_s         pads,
	input  logic                         uart_idle,
	output console_pkg::led_t            led,

	output console_pkg::sram_addr_t      sram_addr,
	inout  wire console_pkg::sram_data_t sram_dq,
	output logic                         sram_we_n,
	output logic                         sram_oe_n,
	output logic [1:0]                   sram_byte_n
);

	logic rst_sys_n;
	console_pkg::sram_ctrl_s sram_cmd;
	console_pkg::sram_data_t sram_rd;
	console_pkg::btn_t btn;
	logic led_load, led_value, led_state;

	reset_gen rstgen (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rst_sys_n (rst_sys_n)
	);

	bus_ctrl ctrl_u (
		.clk_sys (clk_sys), .rst_sys_n (rst_sys_n),
		.awaddr (awaddr), .awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
		.sram_cmd (sram_cmd), .sram_rd (sram_rd), .btn (btn),
		.led_load (led_load), .led_value (led_value), .led_state (led_state)
	);

	sram_phy sram_phy_u (
		.clk_sys (clk_sys), .rst_sys_n (rst_sys_n),
		.ctrl (sram_cmd), .rd_data (sram_rd),
		.sram_addr (sram_addr), .sram_dq (sram_dq), .sram_we_n (sram_we_n),
		.sram_oe_n (sram_oe_n), .sram_byte_n (sram_byte_n)
	);

	gpio_pads gpio_u (
		.clk_sys (clk_sys), .rst_sys_n (rst_sys_n), .pads (pads),
		.led_load (led_load), .led_value (led_value), .uart_idle (uart_idle),
		.btn (btn), .led_state (led_state), .led (led)
	);

endmodule

// ==== verification/console_sva.sv ====
module console_sva (
	input logic                   clk_sys,
	input logic                   rst_sys_n,
	input console_pkg::bus_addr_t awaddr,
	input logic                   awvalid,
	input logic                   awready,
	input logic                   wvalid,
	input logic                   wready,
	input logic                   bvalid,
	input logic                   bready,
	input console_pkg::bus_resp_t bresp,
	input logic                   arready,
	input logic                   rvalid,
	input logic                   rready,
	input console_pkg::bus_data_t rdata,
	input console_pkg::bus_resp_t rresp,
	input logic                   sram_we_n,
	input logic                   sram_oe_n,
	input logic [1:0]             sram_byte_n,
	input logic                   dq_drive
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;
	logic wr_hs;

	assign wr_hs = awvalid && awready && wvalid && wready;

	// ####################################################################
	// host channels

	b_held: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			$error("bvalid dropped or bresp changed before bready");
			fail_count++;
		end

	r_held: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else begin
			$error("rvalid dropped or read payload changed before rready");
			fail_count++;
		end

	// two halfword slots of SRAM_WAIT+1 cycles, then RESP
	sram_wr_latency: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
		wr_hs && awaddr[31:20] == '0 |-> ##(2*(console_pkg::SRAM_WAIT+1)+1) bvalid)
		else begin
			$error("bvalid late after SRAM write handshake");
			fail_count++;
		end

	other_wr_latency: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
		wr_hs && awaddr[31:20] != '0 |-> ##1 bvalid)
		else begin
			$error("bvalid late after non-SRAM write handshake");
			fail_count++;
		end

	// ####################################################################
	// pins

	dq_contention: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
		dq_drive |-> sram_oe_n)
		else begin
			$error("data bus driven while sram_oe_n is low");
			fail_count++;
		end

	reset_quiet: assert property (@(posedge clk_sys)
		!rst_sys_n |=> !awready && !wready && !arready && !bvalid && !rvalid
			&& sram_we_n && sram_oe_n && sram_byte_n == 2'b11 && !dq_drive)
		else begin
			$error("control outputs active during reset");
			fail_count++;
		end

endmodule

// ==== verification/console_tb.sv ====
module console_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_CYCLES = 4000; // 80 accesses of at most 20 cycles doubled plus reset

	logic clk_sys;
	logic rst_n;
	console_pkg::bus_addr_t awaddr, araddr;
	console_pkg::bus_data_t wdata, rdata;
	console_pkg::bus_strb_t wstrb;
	console_pkg::bus_resp_t bresp, rresp;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	console_pkg::pad_in_s pads;
	logic uart_idle;
	console_pkg::led_t led;
	console_pkg::sram_addr_t sram_addr;
	wire console_pkg::sram_data_t sram_dq;
	logic sram_we_n, sram_oe_n;
	logic [1:0] sram_byte_n;

	console_pkg::sram_data_t mem [0:(1 << console_pkg::W_SRAM_ADDR)-1];
	console_pkg::bus_data_t mirror [bit [16:0]]; // word index -> last written word
	int cycles = 0;

	console_top dut (.*);

	bind console_top console_sva sva_u (
		.clk_sys (clk_sys), .rst_sys_n (rst_sys_n), .awaddr (awaddr),
		.awvalid (awvalid), .awready (awready), .wvalid (wvalid), .wready (wready),
		.bvalid (bvalid), .bready (bready), .bresp (bresp), .arready (arready),
		.rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
		.sram_we_n (sram_we_n), .sram_oe_n (sram_oe_n), .sram_byte_n (sram_byte_n),
		.dq_drive (sram_phy_u.dq_oe_q)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ####################################################################
	// SRAM model

	function automatic console_pkg::sram_data_t fill_half(int unsigned hw);
		return console_pkg::sram_data_t'(hw) ^ {hw[17:16], 14'h1d3};
	endfunction

	initial begin
		for (int i = 0; i < (1 << console_pkg::W_SRAM_ADDR); i++)
			mem[i] = fill_half(i);
	end

	assign sram_dq = (sram_oe_n === 1'b0) ? {
		sram_byte_n[1] ? 8'hzz : mem[sram_addr][15:8],
		sram_byte_n[0] ? 8'hzz : mem[sram_addr][7:0]} : 'z;

	// address, data and byte_n hold steady across the rising edge of we_n
	always @(posedge sram_we_n) begin
		if (sram_byte_n[0] === 1'b0)
			mem[sram_addr][7:0] = sram_dq[7:0];
		if (sram_byte_n[1] === 1'b0)
			mem[sram_addr][15:8] = sram_dq[15:8];
	end

	// ####################################################################
	// failure handling

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input console_pkg::bus_data_t expected,
			input console_pkg::bus_data_t actual);
		assert (actual === expected)
		else begin
			$display("** Error at %0d ns: %s expected 0x%h, got 0x%h",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	always @(negedge clk_sys) begin
		if (dut.sva_u.fail_count != 0) begin
			$display("a bound protocol assertion failed");
			abort_run();
		end
	end

	// ####################################################################
	// host driver and scoreboard

	task automatic bus_access(input logic write, input console_pkg::bus_addr_t addr,
			input console_pkg::bus_data_t data, input console_pkg::bus_strb_t strb,
			output console_pkg::bus_data_t rd, output console_pkg::bus_resp_t resp);
		int stall;
		@(negedge clk_sys);
		awaddr = write ? addr : ~addr; // idle channel carries a different address
		araddr = write ? ~addr : addr;
		wdata = data;
		wstrb = strb;
		awvalid = write;
		wvalid = write;
		arvalid = !write;
		@(posedge clk_sys);
		while (!(write ? awready && wready : arready))
			@(posedge clk_sys);
		@(negedge clk_sys);
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		stall = $urandom_range(5); // master back-pressure once valid is up
		forever begin
			bready = write && stall == 0;
			rready = !write && stall == 0;
			@(posedge clk_sys);
			if (write ? bvalid && bready : rvalid && rready)
				break;
			@(negedge clk_sys);
			if (stall > 0 && (write ? bvalid : rvalid))
				stall--;
		end
		rd = rdata;
		resp = write ? bresp : rresp;
		@(negedge clk_sys);
		bready = 1'b0;
		rready = 1'b0;
	endtask

	function automatic console_pkg::bus_addr_t random_sram_addr();
		console_pkg::bus_addr_t a;
		a = console_pkg::SRAM_BASE;
		a[18:2] = 17'($urandom);
		return a;
	endfunction

	function automatic console_pkg::bus_data_t expect_word(console_pkg::bus_addr_t addr);
		int unsigned hw;
		hw = {addr[18:2], 1'b0};
		if (mirror.exists(addr[18:2]))
			return mirror[addr[18:2]];
		return {fill_half(hw + 1), fill_half(hw)};
	endfunction

	function automatic console_pkg::bus_data_t merge_bytes(console_pkg::bus_data_t old,
			console_pkg::bus_data_t data, console_pkg::bus_strb_t strb);
		console_pkg::bus_data_t res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				res[8*b +: 8] = data[8*b +: 8];
		return res;
	endfunction

	// ####################################################################
	// tests

	initial begin : run
		console_pkg::bus_addr_t addr;
		console_pkg::bus_addr_t addr_q[$];
		console_pkg::bus_data_t rd, data;
		console_pkg::bus_resp_t resp;
		console_pkg::bus_strb_t strb;
		console_pkg::btn_t mask;

		void'($urandom(32));
		rst_n = 1'b0;
		{awvalid, wvalid, arvalid, bready, rready} = '0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		pads = '1; // pull-ups hold every pad high
		uart_idle = 1'b0;
		repeat (5) @(negedge clk_sys);
		rst_n = 1'b1;
		while (dut.rst_sys_n !== 1'b1)
			@(posedge clk_sys);
		@(negedge clk_sys);

		// quiet outputs after reset
		check_value("awready,wready,arready,bvalid,rvalid", 0,
			{awready, wready, arready, bvalid, rvalid});
		check_value("sram_we_n,sram_oe_n,sram_byte_n", 'hf,
			{sram_we_n, sram_oe_n, sram_byte_n});
		check_value("led", 'h80, led);
		uart_idle = 1'b1;
		@(negedge clk_sys);
		check_value("led", 'h00, led);

		// full words then read back
		for (int i = 0; i < 16; i++) begin
			addr = random_sram_addr();
			data = $urandom;
			addr_q.push_back(addr);
			bus_access(1'b1, addr, data, 4'hf, rd, resp);
			check_value("bresp", console_pkg::RESP_OKAY, resp);
			mirror[addr[18:2]] = data;
		end
		foreach (addr_q[i]) begin
			bus_access(1'b0, addr_q[i], '0, '0, rd, resp);
			check_value("rresp", console_pkg::RESP_OKAY, resp);
			check_value("rdata", expect_word(addr_q[i]), rd);
		end

		// partial writes to old and fresh words
		for (int i = 0; i < 12; i++) begin
			addr = i[0] ? addr_q[i] : random_sram_addr();
			data = $urandom;
			strb = 4'($urandom);
			bus_access(1'b1, addr, data, strb, rd, resp);
			check_value("bresp", console_pkg::RESP_OKAY, resp);
			mirror[addr[18:2]] = merge_bytes(expect_word(addr), data, strb);
			bus_access(1'b0, addr, '0, '0, rd, resp);
			check_value("rresp", console_pkg::RESP_OKAY, resp);
			check_value("rdata", expect_word(addr), rd);
		end

		// buttons and user led
		for (int i = 0; i < 6; i++) begin
			mask = (i < 5) ? console_pkg::btn_t'(1 << i) : console_pkg::btn_t'($urandom);
			@(negedge clk_sys);
			pads = console_pkg::pad_in_s'(~mask); // pressed pulls low
			repeat (3) @(negedge clk_sys); // two sync flops
			check_value("led[5:1]", mask, led[5:1]);
			bus_access(1'b0, console_pkg::GPIO_BASE + console_pkg::GPIO_IN_OFS, '0, '0,
				rd, resp);
			check_value("rresp", console_pkg::RESP_OKAY, resp);
			check_value("rdata gpio in", mask, rd);
			data = i[0];
			bus_access(1'b1, console_pkg::GPIO_BASE + console_pkg::GPIO_OUT_OFS, data, 4'hf,
				rd, resp);
			check_value("bresp", console_pkg::RESP_OKAY, resp);
			check_value("led[0]", data, led[0]);
			bus_access(1'b0, console_pkg::GPIO_BASE + console_pkg::GPIO_OUT_OFS, '0, '0,
				rd, resp);
			check_value("rresp", console_pkg::RESP_OKAY, resp);
			check_value("rdata gpio out", data, rd);
		end
		pads = '1;

		// unmapped addresses
		addr = addr_q[0];
		data = expect_word(addr);
		// just past the window
		bus_access(1'b1, addr | 32'h0010_0000, ~data, 4'hf, rd, resp);
		check_value("bresp", console_pkg::RESP_DECERR, resp);
		bus_access(1'b1, addr | 32'h4000_0000, ~data, 4'hf, rd, resp);
		check_value("bresp", console_pkg::RESP_DECERR, resp);
		bus_access(1'b1, console_pkg::GPIO_BASE + 32'h8, '1, 4'hf, rd, resp);
		check_value("bresp", console_pkg::RESP_DECERR, resp);
		bus_access(1'b0, addr | 32'h0080_0000, '0, '0, rd, resp);
		check_value("rresp", console_pkg::RESP_DECERR, resp);
		bus_access(1'b0, addr, '0, '0, rd, resp);
		check_value("rresp", console_pkg::RESP_OKAY, resp);
		check_value("rdata after decerr", data, rd);

		if (dut.sva_u.fail_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("bound assertions reported %0d failures", dut.sva_u.fail_count);
			abort_run();
		end
	end

endmodule

// ==== sources.f ====
logic/console_pkg.sv
logic/reset_gen.sv
logic/bus_ctrl.sv
logic/sram_phy.sv
logic/gpio_pads.sv
logic/console_top.sv
verification/console_sva.sv
verification/console_tb.sv

// ==== Bender.yml ====
package:
  name: console_subsystem

sources:
  - logic/console_pkg.sv
  - logic/reset_gen.sv
  - logic/bus_ctrl.sv
  - logic/sram_phy.sv
  - logic/gpio_pads.sv
  - logic/console_top.sv
  - target: test
    files:
      - verification/console_sva.sv
      - verification/console_tb.sv
